// ==== design/rvv_alu_config.svh ====
`ifndef RVV_ALU_CONFIG_SVH
`define RVV_ALU_CONFIG_SVH

// vector register length in bits
`define VLEN 128

// scalar register length
`define XLEN 32

// tag width of a ROB entry
`define ROB_DEPTH_WIDTH 3

// start element index, wide enough for VLEN mask bits
`define VSTART_WIDTH 7

// reservation queue entries
`define RS_DEPTH 4

`endif

// ==== design/rvv_alu_pkg.sv ====
`default_nettype none

`include "rvv_alu_config.svh"

package rvv_alu_pkg;

  typedef logic [`VLEN-1:0]            vreg_t;
  typedef logic [`XLEN-1:0]            xreg_t;
  typedef logic [`ROB_DEPTH_WIDTH-1:0] rob_tag_t;
  typedef logic [`VSTART_WIDTH-1:0]    vstart_t;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  // integer space and mask space codes, funct3 picks the space
  typedef enum logic [5:0] {
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMANDN = 6'b011000,
    VMAND  = 6'b011001,
    VMOR   = 6'b011010,
    VMXOR  = 6'b011011,
    VMORN  = 6'b011100,
    VMNAND = 6'b011101,
    VMNOR  = 6'b011110,
    VMXNOR = 6'b011111
  } funct6_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // bitwise function of vs2 and vs1 for one opcode
  function automatic vreg_t vlogic(funct6_e op, vreg_t vs2, vreg_t vs1);
    vreg_t res;
    case (op)
      VAND, VMAND: res = vs2 & vs1;
      VMANDN:      res = vs2 & ~vs1;
      VOR, VMOR:   res = vs2 | vs1;
      VXOR, VMXOR: res = vs2 ^ vs1;
      VMORN:       res = vs2 | ~vs1;
      VMNAND:      res = ~(vs2 & vs1);
      VMNOR:       res = ~(vs2 | vs1);
      VMXNOR:      res = ~(vs2 ^ vs1);
      default:     res = '0;
    endcase
    return res;
  endfunction

  // scalar repeated over every 32-bit word at the element width
  function automatic vreg_t splat(xreg_t rs1, eew_e eew);
    xreg_t word;
    case (eew)
      EEW8:    word = {4{rs1[7:0]}};
      EEW16:   word = {2{rs1[15:0]}};
      default: word = rs1;
    endcase
    return {(`VLEN/`XLEN){word}};
  endfunction

  // mask bits below vstart keep the old destination
  function automatic vreg_t keep_prestart(vreg_t vd, vreg_t res, vstart_t vstart);
    vreg_t out;
    int    i;
    out = res;
    for (i = 0; i < `VLEN; i++) begin
      if (i < int'(vstart)) out[i] = vd[i];
    end
    return out;
  endfunction

endpackage

`default_nettype wire

// ==== design/rvv_alu_if.sv ====
`default_nettype none

// head of the reservation queue and the decisions made on it
interface alu_uop_if;
  logic                  head_valid;
  rvv_alu_pkg::rob_tag_t rob_entry;
  rvv_alu_pkg::funct6_e  funct6;
  rvv_alu_pkg::funct3_e  funct3;
  rvv_alu_pkg::vstart_t  vstart;
  logic                  vm;
  rvv_alu_pkg::vreg_t    vd_data;
  logic                  vd_valid;
  rvv_alu_pkg::vreg_t    vs1_data;
  logic                  vs1_valid;
  rvv_alu_pkg::vreg_t    vs2_data;
  logic                  vs2_valid;
  rvv_alu_pkg::eew_e     vs2_eew;
  rvv_alu_pkg::xreg_t    rs1_data;
  logic                  rs1_valid;
  logic                  done;
  logic                  reject;
  logic                  take;

  modport rs (
    output head_valid, rob_entry, funct6, funct3, vstart, vm, vd_data, vd_valid,
           vs1_data, vs1_valid, vs2_data, vs2_valid, vs2_eew, rs1_data, rs1_valid,
    input  done, reject, take
  );

  modport unit (
    input  head_valid, rob_entry, funct6, funct3, vstart, vm, vd_data, vd_valid,
           vs1_data, vs1_valid, vs2_data, vs2_valid, vs2_eew, rs1_data, rs1_valid,
    output done, reject
  );

  modport res (
    input  done, reject, rob_entry,
    output take
  );
endinterface

// write-back toward the ROB
interface rob_result_if;
  logic                  w_valid;
  rvv_alu_pkg::rob_tag_t rob_entry;
  rvv_alu_pkg::vreg_t    w_data;
  logic                  vxsat;
  logic                  ignore_vta;
  logic                  ignore_vma;

  modport unit (output w_valid, rob_entry, w_data, vxsat, ignore_vta, ignore_vma);
  modport res  (input  w_valid, rob_entry, w_data, vxsat, ignore_vta, ignore_vma);
endinterface

`default_nettype wire

// ==== design/rvv_alu_rs.sv ====
`default_nettype none

`include "rvv_alu_config.svh"

module rvv_alu_rs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  in_valid,
  input  rvv_alu_pkg::rob_tag_t in_rob_entry,
  input  rvv_alu_pkg::funct6_e  in_funct6,
  input  rvv_alu_pkg::funct3_e  in_funct3,
  input  rvv_alu_pkg::vstart_t  in_vstart,
  input  logic                  in_vm,
  input  rvv_alu_pkg::vreg_t    in_vd_data,
  input  logic                  in_vd_valid,
  input  rvv_alu_pkg::vreg_t    in_vs1_data,
  input  logic                  in_vs1_valid,
  input  rvv_alu_pkg::vreg_t    in_vs2_data,
  input  logic                  in_vs2_valid,
  input  rvv_alu_pkg::eew_e     in_vs2_eew,
  input  rvv_alu_pkg::xreg_t    in_rs1_data,
  input  logic                  in_rs1_valid,
  output logic                  in_ready,
  alu_uop_if.rs                 head
);

  localparam int PTR_W = $clog2(`RS_DEPTH);
  localparam int CNT_W = $clog2(`RS_DEPTH + 1);

  typedef struct packed {
    rvv_alu_pkg::rob_tag_t rob_entry;
    rvv_alu_pkg::funct6_e  funct6;
    rvv_alu_pkg::funct3_e  funct3;
    rvv_alu_pkg::vstart_t  vstart;
    logic                  vm;
    rvv_alu_pkg::vreg_t    vd_data;
    logic                  vd_valid;
    rvv_alu_pkg::vreg_t    vs1_data;
    logic                  vs1_valid;
    rvv_alu_pkg::vreg_t    vs2_data;
    logic                  vs2_valid;
    rvv_alu_pkg::eew_e     vs2_eew;
    rvv_alu_pkg::xreg_t    rs1_data;
    logic                  rs1_valid;
  } entry_t;

  entry_t           mem [`RS_DEPTH];
  entry_t           head_entry;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(`RS_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_ready = (count != CNT_W'(`RS_DEPTH));
  assign push     = in_valid & in_ready;
  // head leaves once the unit decided and the result side can take it
  assign pop      = head.head_valid & head.take & (head.done | head.reject);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{in_rob_entry, in_funct6, in_funct3, in_vstart, in_vm,
                       in_vd_data, in_vd_valid, in_vs1_data, in_vs1_valid,
                       in_vs2_data, in_vs2_valid, in_vs2_eew, in_rs1_data,
                       in_rs1_valid};
    end
  end

  assign head_entry      = mem[rd_ptr];
  assign head.head_valid = (count != '0);
  assign head.rob_entry  = head_entry.rob_entry;
  assign head.funct6     = head_entry.funct6;
  assign head.funct3     = head_entry.funct3;
  assign head.vstart     = head_entry.vstart;
  assign head.vm         = head_entry.vm;
  assign head.vd_data    = head_entry.vd_data;
  assign head.vd_valid   = head_entry.vd_valid;
  assign head.vs1_data   = head_entry.vs1_data;
  assign head.vs1_valid  = head_entry.vs1_valid;
  assign head.vs2_data   = head_entry.vs2_data;
  assign head.vs2_valid  = head_entry.vs2_valid;
  assign head.vs2_eew    = head_entry.vs2_eew;
  assign head.rs1_data   = head_entry.rs1_data;
  assign head.rs1_valid  = head_entry.rs1_valid;

endmodule

`default_nettype wire

// ==== design/rvv_alu_unit_mask.sv ====
`default_nettype none

module rvv_alu_unit_mask (
  alu_uop_if.unit    uop,
  rob_result_if.unit result
);

  logic               is_logic;
  logic               is_mask;
  logic               opnd_ok;
  logic               accept;
  rvv_alu_pkg::vreg_t src1;
  rvv_alu_pkg::vreg_t logic_res;

  // decode the funct3/funct6 pair
  always_comb begin
    is_logic = 1'b0;
    is_mask  = 1'b0;
    case (uop.funct3)
      rvv_alu_pkg::OPIVV,
      rvv_alu_pkg::OPIVX,
      rvv_alu_pkg::OPIVI: begin
        case (uop.funct6)
          rvv_alu_pkg::VAND,
          rvv_alu_pkg::VOR,
          rvv_alu_pkg::VXOR: begin
            is_logic = 1'b1;
          end
          default: begin
            is_logic = 1'b0;
          end
        endcase
      end
      rvv_alu_pkg::OPMVV: begin
        case (uop.funct6)
          rvv_alu_pkg::VMANDN,
          rvv_alu_pkg::VMAND,
          rvv_alu_pkg::VMOR,
          rvv_alu_pkg::VMXOR,
          rvv_alu_pkg::VMORN,
          rvv_alu_pkg::VMNAND,
          rvv_alu_pkg::VMNOR,
          rvv_alu_pkg::VMXNOR: begin
            is_mask = 1'b1;
          end
          default: begin
            is_mask = 1'b0;
          end
        endcase
      end
      default: begin
        is_logic = 1'b0;
        is_mask  = 1'b0;
      end
    endcase
  end

  // operand readiness per form, scalar forms use the splatted rs1
  always_comb begin
    opnd_ok = 1'b0;
    src1    = uop.vs1_data;
    case (uop.funct3)
      rvv_alu_pkg::OPIVV: begin
        opnd_ok = uop.vs1_valid & uop.vs2_valid;
      end
      rvv_alu_pkg::OPIVX,
      rvv_alu_pkg::OPIVI: begin
        opnd_ok = uop.rs1_valid & uop.vs2_valid;
        src1    = rvv_alu_pkg::splat(uop.rs1_data, uop.vs2_eew);
      end
      rvv_alu_pkg::OPMVV: begin
        // masked form of a mask op is not legal
        opnd_ok = uop.vs1_valid & uop.vs2_valid & uop.vd_valid & uop.vm;
      end
      default: begin
        opnd_ok = 1'b0;
      end
    endcase
  end

  assign logic_res = rvv_alu_pkg::vlogic(uop.funct6, uop.vs2_data, src1);

  assign accept     = uop.head_valid & (is_logic | is_mask) & opnd_ok;
  assign uop.done   = accept;
  assign uop.reject = uop.head_valid & ~accept;

  assign result.w_valid   = accept;
  assign result.rob_entry = uop.rob_entry;
  // prestart mask bits come from the old vd
  assign result.w_data    = is_mask ?
                            rvv_alu_pkg::keep_prestart(uop.vd_data, logic_res, uop.vstart) :
                            logic_res;
  assign result.vxsat      = 1'b0;
  assign result.ignore_vta = is_mask;
  assign result.ignore_vma = 1'b0;

endmodule

`default_nettype wire

// ==== design/rvv_alu_result_reg.sv ====
`default_nettype none

module rvv_alu_result_reg (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  rob_ready,
  rob_result_if.res             result,
  alu_uop_if.res                uop,
  output logic                  result_valid,
  output rvv_alu_pkg::rob_tag_t result_rob_entry,
  output rvv_alu_pkg::vreg_t    result_w_data,
  output logic                  result_vxsat,
  output logic                  result_ignore_vta,
  output logic                  result_ignore_vma,
  output logic                  uop_reject,
  output rvv_alu_pkg::rob_tag_t reject_rob_entry
);

  logic valid_q;
  logic reject_q;

  // free slot, or the held result leaves this cycle
  assign uop.take = ~valid_q | rob_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= 1'b0;
      reject_q <= 1'b0;
    end else begin
      if (uop.take) valid_q <= result.w_valid;
      reject_q <= uop.reject & uop.take;
    end
  end

  always_ff @(posedge clk) begin
    if (uop.take && uop.done) begin
      result_rob_entry  <= result.rob_entry;
      result_w_data     <= result.w_data;
      result_vxsat      <= result.vxsat;
      result_ignore_vta <= result.ignore_vta;
      result_ignore_vma <= result.ignore_vma;
    end
    if (uop.take && uop.reject) begin
      reject_rob_entry <= uop.rob_entry;
    end
  end

  assign result_valid = valid_q;
  assign uop_reject   = reject_q;

endmodule

`default_nettype wire

// ==== design/rvv_alu_top.sv ====
`default_nettype none

module rvv_alu_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  input  rvv_alu_pkg::rob_tag_t uop_rob_entry,
  input  rvv_alu_pkg::funct6_e  uop_funct6,
  input  rvv_alu_pkg::funct3_e  uop_funct3,
  input  rvv_alu_pkg::vstart_t  uop_vstart,
  input  logic                  uop_vm,
  input  rvv_alu_pkg::vreg_t    uop_vd_data,
  input  logic                  uop_vd_valid,
  input  rvv_alu_pkg::vreg_t    uop_vs1_data,
  input  logic                  uop_vs1_valid,
  input  rvv_alu_pkg::vreg_t    uop_vs2_data,
  input  logic                  uop_vs2_valid,
  input  rvv_alu_pkg::eew_e     uop_vs2_eew,
  input  rvv_alu_pkg::xreg_t    uop_rs1_data,
  input  logic                  uop_rs1_valid,
  output logic                  uop_ready,
  input  logic                  rob_ready,
  output logic                  result_valid,
  output rvv_alu_pkg::rob_tag_t result_rob_entry,
  output rvv_alu_pkg::vreg_t    result_w_data,
  output logic                  result_vxsat,
  output logic                  result_ignore_vta,
  output logic                  result_ignore_vma,
  output logic                  uop_reject,
  output rvv_alu_pkg::rob_tag_t reject_rob_entry
);

  alu_uop_if    uop_bus ();
  rob_result_if res_bus ();

  rvv_alu_rs u_rs (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (uop_valid),
    .in_rob_entry (uop_rob_entry),
    .in_funct6    (uop_funct6),
    .in_funct3    (uop_funct3),
    .in_vstart    (uop_vstart),
    .in_vm        (uop_vm),
    .in_vd_data   (uop_vd_data),
    .in_vd_valid  (uop_vd_valid),
    .in_vs1_data  (uop_vs1_data),
    .in_vs1_valid (uop_vs1_valid),
    .in_vs2_data  (uop_vs2_data),
    .in_vs2_valid (uop_vs2_valid),
    .in_vs2_eew   (uop_vs2_eew),
    .in_rs1_data  (uop_rs1_data),
    .in_rs1_valid (uop_rs1_valid),
    .in_ready     (uop_ready),
    .head         (uop_bus.rs)
  );

  rvv_alu_unit_mask u_unit (
    .uop    (uop_bus.unit),
    .result (res_bus.unit)
  );

  rvv_alu_result_reg u_result (
    .clk               (clk),
    .arst_n            (arst_n),
    .rob_ready         (rob_ready),
    .result            (res_bus.res),
    .uop               (uop_bus.res),
    .result_valid      (result_valid),
    .result_rob_entry  (result_rob_entry),
    .result_w_data     (result_w_data),
    .result_vxsat      (result_vxsat),
    .result_ignore_vta (result_ignore_vta),
    .result_ignore_vma (result_ignore_vma),
    .uop_reject        (uop_reject),
    .reject_rob_entry  (reject_rob_entry)
  );

endmodule

`default_nettype wire

// ==== testbench/rvv_alu_props.sv ====
`default_nettype none

module rvv_alu_props (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  uop_ready,
  input logic                  rob_ready,
  input logic                  result_valid,
  input rvv_alu_pkg::rob_tag_t result_rob_entry,
  input rvv_alu_pkg::vreg_t    result_w_data,
  input logic                  uop_reject,
  input rvv_alu_pkg::rob_tag_t reject_rob_entry
);

  int unsigned fail_count = 0;

  // held result keeps tag and data until the ROB takes it
  hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && !rob_ready |=> result_valid && $stable(result_w_data)
                                   && $stable(result_rob_entry))
    else begin
      fail_count++;
      $error("held result changed while rob_ready was low");
    end

  // one pulse per rejected tag
  reject_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    uop_reject |=> !uop_reject || reject_rob_entry != $past(reject_rob_entry))
    else begin
      fail_count++;
      $error("uop_reject stayed high for the same tag");
    end

  reset_values: assert property (@(posedge clk)
    $rose(arst_n) |-> uop_ready && !result_valid && !uop_reject)
    else begin
      fail_count++;
      $error("outputs left reset with wrong values");
    end

  // a full queue takes nothing until an entry leaves
  full_holds: assert property (@(posedge clk) disable iff (!arst_n)
    !uop_ready && !(result_valid && rob_ready)
      |=> !uop_ready || uop_reject || $rose(result_valid))
    else begin
      fail_count++;
      $error("queue accepted a micro-op while full");
    end

endmodule

bind rvv_alu_top rvv_alu_props props0 (
  .clk              (clk),
  .arst_n           (arst_n),
  .uop_ready        (uop_ready),
  .rob_ready        (rob_ready),
  .result_valid     (result_valid),
  .result_rob_entry (result_rob_entry),
  .result_w_data    (result_w_data),
  .uop_reject       (uop_reject),
  .reject_rob_entry (reject_rob_entry)
);

`default_nettype wire

// ==== testbench/rvv_alu_tb.sv ====
`default_nettype none

`include "rvv_alu_config.svh"

module rvv_alu_tb;

  localparam int N_DIRECTED = 49;
  localparam int N_RAND     = 150;

  logic                  clk;
  logic                  arst_n;
  logic                  uop_valid;
  rvv_alu_pkg::rob_tag_t uop_rob_entry;
  rvv_alu_pkg::funct6_e  uop_funct6;
  rvv_alu_pkg::funct3_e  uop_funct3;
  rvv_alu_pkg::vstart_t  uop_vstart;
  logic                  uop_vm;
  rvv_alu_pkg::vreg_t    uop_vd_data;
  logic                  uop_vd_valid;
  rvv_alu_pkg::vreg_t    uop_vs1_data;
  logic                  uop_vs1_valid;
  rvv_alu_pkg::vreg_t    uop_vs2_data;
  logic                  uop_vs2_valid;
  rvv_alu_pkg::eew_e     uop_vs2_eew;
  rvv_alu_pkg::xreg_t    uop_rs1_data;
  logic                  uop_rs1_valid;
  logic                  uop_ready;
  logic                  rob_ready;
  logic                  result_valid;
  rvv_alu_pkg::rob_tag_t result_rob_entry;
  rvv_alu_pkg::vreg_t    result_w_data;
  logic                  result_vxsat;
  logic                  result_ignore_vta;
  logic                  result_ignore_vma;
  logic                  uop_reject;
  rvv_alu_pkg::rob_tag_t reject_rob_entry;

  // expected outcomes in acceptance order
  rvv_alu_pkg::rob_tag_t exp_tag [$];
  rvv_alu_pkg::vreg_t    exp_data [$];
  logic                  exp_rej [$];
  logic                  exp_vta [$];
  int                    errors;
  int                    checks;
  int                    sent;

  rvv_alu_pkg::funct3_e iv_forms [3] = '{rvv_alu_pkg::OPIVV, rvv_alu_pkg::OPIVX,
                                         rvv_alu_pkg::OPIVI};
  rvv_alu_pkg::funct6_e int_ops [3]  = '{rvv_alu_pkg::VAND, rvv_alu_pkg::VOR,
                                         rvv_alu_pkg::VXOR};
  rvv_alu_pkg::funct6_e mask_ops [8] = '{rvv_alu_pkg::VMANDN, rvv_alu_pkg::VMAND,
                                         rvv_alu_pkg::VMOR, rvv_alu_pkg::VMXOR,
                                         rvv_alu_pkg::VMORN, rvv_alu_pkg::VMNAND,
                                         rvv_alu_pkg::VMNOR, rvv_alu_pkg::VMXNOR};
  rvv_alu_pkg::eew_e    eews [3]     = '{rvv_alu_pkg::EEW8, rvv_alu_pkg::EEW16,
                                         rvv_alu_pkg::EEW32};

  rvv_alu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // truth table per op, indexed by {vs2 bit, vs1 bit}
  function automatic logic [3:0] truth(rvv_alu_pkg::funct6_e op);
    case (op)
      rvv_alu_pkg::VAND, rvv_alu_pkg::VMAND: return 4'b1000;
      rvv_alu_pkg::VMANDN:                   return 4'b0100;
      rvv_alu_pkg::VOR, rvv_alu_pkg::VMOR:   return 4'b1110;
      rvv_alu_pkg::VXOR, rvv_alu_pkg::VMXOR: return 4'b0110;
      rvv_alu_pkg::VMORN:                    return 4'b1101;
      rvv_alu_pkg::VMNAND:                   return 4'b0111;
      rvv_alu_pkg::VMNOR:                    return 4'b0001;
      rvv_alu_pkg::VMXNOR:                   return 4'b1001;
      default:                               return 4'b0000;
    endcase
  endfunction

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  task automatic retire_expected();
    exp_tag.delete(0);
    exp_data.delete(0);
    exp_rej.delete(0);
    exp_vta.delete(0);
  endtask

  // ok holds the operand valid bits {vd, vs1, vs2, rs1}
  task automatic send_uop(input rvv_alu_pkg::funct3_e form, input rvv_alu_pkg::funct6_e op,
                          input rvv_alu_pkg::eew_e eew, input logic vm, input logic [3:0] ok);
    rvv_alu_pkg::vreg_t src1;
    rvv_alu_pkg::vreg_t res;
    logic [3:0]         tt;
    logic               legal;
    logic               ops_ok;
    int                 i;
    int                 n;
    uop_rob_entry = rvv_alu_pkg::rob_tag_t'(sent);
    uop_funct3    = form;
    uop_funct6    = op;
    uop_vs2_eew   = eew;
    uop_vm        = vm;
    {uop_vd_valid, uop_vs1_valid, uop_vs2_valid, uop_rs1_valid} = ok;
    uop_vstart    = rvv_alu_pkg::vstart_t'($urandom);
    uop_rs1_data  = $urandom;
    for (i = 0; i < `VLEN / 32; i++) begin
      uop_vd_data[32*i +: 32]  = $urandom;
      uop_vs1_data[32*i +: 32] = $urandom;
      uop_vs2_data[32*i +: 32] = $urandom;
    end
    if (form == rvv_alu_pkg::OPMVV) begin
      legal  = !(op inside {rvv_alu_pkg::VAND, rvv_alu_pkg::VOR, rvv_alu_pkg::VXOR});
      ops_ok = ok[3] & ok[2] & ok[1] & vm;
    end else begin
      legal  = op inside {rvv_alu_pkg::VAND, rvv_alu_pkg::VOR, rvv_alu_pkg::VXOR};
      ops_ok = ok[1] & ((form == rvv_alu_pkg::OPIVV) ? ok[2] : ok[0]);
    end
    // bytes of the scalar repeat every element
    n = (eew == rvv_alu_pkg::EEW8) ? 1 : (eew == rvv_alu_pkg::EEW16) ? 2 : 4;
    for (i = 0; i < `VLEN / 8; i++) begin
      src1[8*i +: 8] = (form == rvv_alu_pkg::OPIVV || form == rvv_alu_pkg::OPMVV) ?
                       uop_vs1_data[8*i +: 8] : uop_rs1_data[8*(i % n) +: 8];
    end
    tt = truth(op);
    for (i = 0; i < `VLEN; i++) begin
      res[i] = (form == rvv_alu_pkg::OPMVV && i < int'(uop_vstart)) ?
               uop_vd_data[i] : tt[{uop_vs2_data[i], src1[i]}];
    end
    uop_valid = 1'b1;
    @(negedge clk);
    while (!uop_ready) @(negedge clk);
    @(posedge clk);
    exp_tag.push_back(uop_rob_entry);
    exp_data.push_back(res);
    exp_rej.push_back(!(legal && ops_ok));
    exp_vta.push_back(form == rvv_alu_pkg::OPMVV);
    sent++;
    #1;
    uop_valid = 1'b0;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n && result_valid && rob_ready) begin
      if (exp_tag.size() == 0) begin
        errors++;
        $display("result with tag %0d arrived while nothing was outstanding", result_rob_entry);
      end else begin
        checks++;
        assert (!exp_rej[0] && result_rob_entry == exp_tag[0] && result_w_data == exp_data[0]
                && result_ignore_vta == exp_vta[0] && !result_ignore_vma && !result_vxsat)
          else flag_mismatch($sformatf("result tag %0d data %h, expected tag %0d data %h rej %0b",
                             result_rob_entry, result_w_data, exp_tag[0], exp_data[0],
                             exp_rej[0]));
        retire_expected();
      end
    end
    if (arst_n && uop_reject) begin
      if (exp_tag.size() == 0) begin
        errors++;
        $display("reject of tag %0d arrived while nothing was outstanding", reject_rob_entry);
      end else begin
        checks++;
        assert (exp_rej[0] && reject_rob_entry == exp_tag[0])
          else flag_mismatch($sformatf("reject of tag %0d, expected tag %0d rej %0b",
                             reject_rob_entry, exp_tag[0], exp_rej[0]));
        retire_expected();
      end
    end
  end

  // random stretches of ROB back-pressure
  initial begin
    rob_ready = 1'b1;
    wait (arst_n === 1'b0);
    wait (arst_n === 1'b1);
    forever begin
      repeat ($urandom_range(1, 12)) @(posedge clk);
      #1;
      rob_ready = ~rob_ready;
    end
  end

  initial begin
    #((N_DIRECTED + N_RAND) * 40 * 4 + 200 * 4);
    $display("timeout: the run did not finish, %0d micro-ops still outstanding", exp_tag.size());
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rvv_alu_pkg::funct3_e form;
    rvv_alu_pkg::funct6_e op;
    logic [3:0]           ok;
    int                   f;
    int                   o;
    int                   e;
    int                   k;
    void'($urandom(32'h16a0));
    errors = 0;
    checks = 0;
    sent   = 0;
    arst_n = 1'b1;
    uop_valid     = 1'b0;
    uop_rob_entry = '0;
    uop_funct6    = rvv_alu_pkg::VAND;
    uop_funct3    = rvv_alu_pkg::OPIVV;
    uop_vs2_eew   = rvv_alu_pkg::EEW8;
    uop_vstart    = '0;
    uop_rs1_data  = '0;
    {uop_vd_data, uop_vs1_data, uop_vs2_data} = '0;
    {uop_vm, uop_vd_valid, uop_vs1_valid, uop_vs2_valid, uop_rs1_valid} = '0;
    #1;
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    checks++;
    assert (uop_ready && !result_valid && !uop_reject)
      else flag_mismatch("uop_ready, result_valid or uop_reject wrong after reset");
    for (f = 0; f < 3; f++)
      for (o = 0; o < 3; o++)
        for (e = 0; e < 3; e++)
          send_uop(iv_forms[f], int_ops[o], eews[e], 1'b1, 4'b1111);
    for (k = 0; k < 16; k++) begin
      send_uop(rvv_alu_pkg::OPMVV, mask_ops[k % 8], rvv_alu_pkg::EEW8, 1'b1, 4'b1111);
    end
    // missing operands, masked mask op, codes from the wrong space
    send_uop(rvv_alu_pkg::OPIVV, rvv_alu_pkg::VAND, rvv_alu_pkg::EEW8, 1'b1, 4'b1011);
    send_uop(rvv_alu_pkg::OPIVX, rvv_alu_pkg::VOR, rvv_alu_pkg::EEW16, 1'b1, 4'b1110);
    send_uop(rvv_alu_pkg::OPMVV, rvv_alu_pkg::VMAND, rvv_alu_pkg::EEW8, 1'b0, 4'b1111);
    send_uop(rvv_alu_pkg::OPMVV, rvv_alu_pkg::VMOR, rvv_alu_pkg::EEW8, 1'b1, 4'b0111);
    send_uop(rvv_alu_pkg::OPIVV, rvv_alu_pkg::VMXOR, rvv_alu_pkg::EEW32, 1'b1, 4'b1111);
    send_uop(rvv_alu_pkg::OPMVV, rvv_alu_pkg::VXOR, rvv_alu_pkg::EEW8, 1'b1, 4'b1111);
    for (k = 0; k < N_RAND; k++) begin
      f    = $urandom_range(0, 3);
      form = (f == 3) ? rvv_alu_pkg::OPMVV : iv_forms[f];
      op   = (f == 3) ? mask_ops[$urandom_range(0, 7)] : int_ops[$urandom_range(0, 2)];
      if ($urandom_range(0, 15) == 0) begin
        op = (f == 3) ? int_ops[0] : mask_ops[$urandom_range(0, 7)];
      end
      ok = ($urandom_range(0, 7) == 0) ? 4'($urandom) : 4'b1111;
      send_uop(form, op, eews[$urandom_range(0, 2)], $urandom_range(0, 15) != 0, ok);
    end
    while (exp_tag.size() != 0) @(negedge clk);
    repeat (4) @(posedge clk);
    $display("checks %0d, testbench errors %0d, assertion failures %0d",
             checks, errors, dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/rvv_alu_pkg.sv
design/rvv_alu_if.sv
design/rvv_alu_rs.sv
design/rvv_alu_unit_mask.sv
design/rvv_alu_result_reg.sv
design/rvv_alu_top.sv
testbench/rvv_alu_props.sv
testbench/rvv_alu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rvv_alu_tb -f list.f -o rvv_alu_sim

./obj_dir/rvv_alu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -qF '*** PASSED ***' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
